// ==== design/doc_pkg.sv ====
/* wavetable engine shared definitions */

package doc_pkg;

    // oscillator index width, 32 oscillators in the register arrays
    localparam int osc_num_w = 5;

    // basic words
    typedef logic [7:0] reg_byte_t;
    typedef logic [15:0] freq_t;
    typedef logic [23:0] acc_t;
    typedef logic [15:0] wave_addr_t;
    typedef logic signed [15:0] sample_t;

    // register group codes taken from host address bits 7..5
    localparam logic [2:0] grp_freq_lo = 3'd0;
    localparam logic [2:0] grp_freq_hi = 3'd1;
    localparam logic [2:0] grp_volume = 3'd2;
    localparam logic [2:0] grp_wave_ptr = 3'd4;
    localparam logic [2:0] grp_control = 3'd5;
    localparam logic [2:0] grp_res_size = 3'd6;
    localparam logic [2:0] grp_global = 3'd7;

    // low address bits of the enable register inside the global group
    localparam logic [osc_num_w-1:0] global_osc_enable = 5'd1;

    // oscillator mode field, control bits 2..1
    localparam logic [1:0] mode_free_run = 2'd0;
    localparam logic [1:0] mode_one_shot = 2'd1;

    // unsigned midpoint of a wave byte, the silent level
    localparam logic [7:0] wave_zero_level = 8'h80;

    // accumulator shift is this base plus resolution minus table size
    localparam int addr_base_shift = 9;

endpackage

// ==== design/doc_register_file.sv ====
/* oscillator register file */

`timescale 1ns/1ps

module doc_register_file (
    input  logic                          clk_i,
    input  logic                          reset_n_i,
    input  logic                          host_we_i,
    input  doc_pkg::reg_byte_t            host_addr_i,
    input  doc_pkg::reg_byte_t            host_data_i,
    input  logic [doc_pkg::osc_num_w-1:0] cur_osc_i,
    input  logic                          halt_req_i,
    input  logic [doc_pkg::osc_num_w-1:0] halt_osc_i,
    output doc_pkg::freq_t                freq_o,
    output doc_pkg::reg_byte_t            volume_o,
    output doc_pkg::reg_byte_t            wave_ptr_o,
    output doc_pkg::reg_byte_t            control_o,
    output doc_pkg::reg_byte_t            res_size_o,
    output logic [5:0]                    osc_count_o
);

    localparam int num_osc = 1 << doc_pkg::osc_num_w;

    // one byte per oscillator in each group
    doc_pkg::reg_byte_t freq_lo_r [num_osc];
    doc_pkg::reg_byte_t freq_hi_r [num_osc];
    doc_pkg::reg_byte_t volume_r [num_osc];
    doc_pkg::reg_byte_t wave_ptr_r [num_osc];
    doc_pkg::reg_byte_t control_r [num_osc];
    doc_pkg::reg_byte_t res_size_r [num_osc];
    doc_pkg::reg_byte_t osc_enable_r;

    logic [2:0]                    host_grp_w;
    logic [doc_pkg::osc_num_w-1:0] host_osc_w;
    logic [4:0]                    enabled_w;

    assign host_grp_w = host_addr_i[7:5];
    assign host_osc_w = host_addr_i[4:0];

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            for (int i = 0; i < num_osc; i++) begin
                freq_lo_r[i] <= '0;
                freq_hi_r[i] <= '0;
                volume_r[i] <= '0;
                wave_ptr_r[i] <= '0;
                control_r[i] <= '0;
                res_size_r[i] <= '0;
            end
            // a single oscillator is enabled out of reset
            osc_enable_r <= 8'h02;
        end else begin
            // the sequencer only ever sets the halt bit
            if (halt_req_i) begin
                control_r[halt_osc_i] <= control_r[halt_osc_i] | 8'h01;
            end
            // host writes come last so they override a halt on the same byte
            if (host_we_i) begin
                case (host_grp_w)
                    doc_pkg::grp_freq_lo:  freq_lo_r[host_osc_w] <= host_data_i;
                    doc_pkg::grp_freq_hi:  freq_hi_r[host_osc_w] <= host_data_i;
                    doc_pkg::grp_volume:   volume_r[host_osc_w] <= host_data_i;
                    doc_pkg::grp_wave_ptr: wave_ptr_r[host_osc_w] <= host_data_i;
                    doc_pkg::grp_control:  control_r[host_osc_w] <= host_data_i;
                    doc_pkg::grp_res_size: res_size_r[host_osc_w] <= host_data_i;
                    doc_pkg::grp_global: begin
                        if (host_osc_w == doc_pkg::global_osc_enable) begin
                            osc_enable_r <= host_data_i;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // registers of the oscillator the sequencer is working on
    assign freq_o = {freq_hi_r[cur_osc_i], freq_lo_r[cur_osc_i]};
    assign volume_o = volume_r[cur_osc_i];
    assign wave_ptr_o = wave_ptr_r[cur_osc_i];
    assign control_o = control_r[cur_osc_i];
    assign res_size_o = res_size_r[cur_osc_i];

    // enable register holds twice the oscillator count, never fewer than one
    assign enabled_w = osc_enable_r[5:1];
    assign osc_count_o = (enabled_w == 5'd0) ? 6'd1 : {1'b0, enabled_w};

endmodule

// ==== design/osc_sequencer.sv ====
/* oscillator sequencer */

`timescale 1ns/1ps

module osc_sequencer (
    input  logic                          clk_i,
    input  logic                          reset_n_i,
    input  doc_pkg::freq_t                freq_i,
    input  doc_pkg::reg_byte_t            volume_i,
    input  doc_pkg::reg_byte_t            wave_ptr_i,
    input  doc_pkg::reg_byte_t            control_i,
    input  doc_pkg::reg_byte_t            res_size_i,
    input  logic [5:0]                    osc_count_i,
    input  logic                          wave_rd_ready_i,
    input  doc_pkg::reg_byte_t            wave_data_i,
    input  logic                          sample_ready_i,
    output logic [doc_pkg::osc_num_w-1:0] cur_osc_o,
    output logic                          halt_req_o,
    output logic [doc_pkg::osc_num_w-1:0] halt_osc_o,
    output logic                          wave_rd_valid_o,
    output doc_pkg::wave_addr_t           wave_addr_o,
    output logic                          sample_valid_o,
    output doc_pkg::sample_t              sample_o,
    output logic                          sample_last_o
);

    localparam int num_osc = 1 << doc_pkg::osc_num_w;

    typedef enum logic [1:0] {st_load, st_step, st_fetch, st_emit} state_t;

    state_t state_r;

    // accumulators live here, the host never sees them
    doc_pkg::acc_t acc_mem [num_osc];
    doc_pkg::acc_t acc_cur_r;

    logic [2:0]          size_w;
    logic [2:0]          res_w;
    logic                halted_w;
    logic                end_halt_w;
    doc_pkg::acc_t       acc_sum_w;
    logic [4:0]          shift_w;
    doc_pkg::wave_addr_t step_addr_w;
    logic [3:0]          top_bit_w;
    logic                overflow_w;
    doc_pkg::wave_addr_t offset_mask_w;
    doc_pkg::reg_byte_t  page_w;
    doc_pkg::wave_addr_t byte_addr_w;
    logic                start_fetch_w;
    logic                fetch_done_w;
    logic                zero_byte_w;
    logic signed [7:0]   wave_s_w;
    logic signed [7:0]   vol_s_w;
    logic signed [15:0]  product_w;
    logic                last_w;

    assign size_w = res_size_i[5:3];
    assign res_w = res_size_i[2:0];
    assign halted_w = control_i[0];

    // what happens at the end of the table depends on the mode field
    always_comb begin
        case (control_i[2:1])
            doc_pkg::mode_one_shot: end_halt_w = 1'b1;
            doc_pkg::mode_free_run: end_halt_w = 1'b0;
            // the remaining codes keep running like free-run
            default:                end_halt_w = 1'b0;
        endcase
    end

    // accumulator step and the address window it selects
    assign acc_sum_w = acc_cur_r + doc_pkg::acc_t'(freq_i);
    assign shift_w = 5'(doc_pkg::addr_base_shift) + 5'(res_w) - 5'(size_w);
    assign step_addr_w = doc_pkg::wave_addr_t'(acc_sum_w >> shift_w);
    assign top_bit_w = {1'b1, size_w};
    assign overflow_w = step_addr_w[top_bit_w];

    // the table starts on a page boundary aligned to its own size
    assign offset_mask_w = ~(16'hFFFF << top_bit_w);
    assign page_w = wave_ptr_i & (8'hFF << size_w);
    assign byte_addr_w = {page_w, 8'h00} | (overflow_w ? '0 : (step_addr_w & offset_mask_w));

    // a halted oscillator or a finished one-shot needs no memory access
    assign start_fetch_w = !halted_w && !(overflow_w && end_halt_w);

    assign fetch_done_w = wave_rd_valid_o && wave_rd_ready_i;
    assign zero_byte_w = (wave_data_i == 8'h00);

    // wave byte made signed around the midpoint, volume reduced to six bits
    assign wave_s_w = signed'(wave_data_i ^ doc_pkg::wave_zero_level);
    assign vol_s_w = signed'({2'b00, volume_i[7:2]});
    assign product_w = wave_s_w * vol_s_w;

    // last index also catches a count that shrank under the sequencer
    assign last_w = ({1'b0, cur_osc_o} >= (osc_count_i - 6'd1));

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            state_r <= st_load;
            cur_osc_o <= '0;
            wave_rd_valid_o <= 1'b0;
            sample_valid_o <= 1'b0;
            halt_req_o <= 1'b0;
        end else begin
            halt_req_o <= 1'b0;
            case (state_r)
                st_load: begin
                    state_r <= st_step;
                end
                st_step: begin
                    state_r <= st_fetch;
                    wave_rd_valid_o <= start_fetch_w;
                    // one-shot reached the end of its table
                    halt_req_o <= !halted_w && overflow_w && end_halt_w;
                end
                st_fetch: begin
                    if (!wave_rd_valid_o) begin
                        state_r <= st_emit;
                        sample_valid_o <= 1'b1;
                    end else if (wave_rd_ready_i) begin
                        wave_rd_valid_o <= 1'b0;
                        state_r <= st_emit;
                        sample_valid_o <= 1'b1;
                        halt_req_o <= zero_byte_w;
                    end
                end
                default: begin
                    // sample and oscillator index hold while the FIFO is full
                    if (sample_ready_i) begin
                        sample_valid_o <= 1'b0;
                        cur_osc_o <= sample_last_o ? '0 : cur_osc_o + 1'b1;
                        state_r <= st_load;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_r == st_load) begin
            acc_cur_r <= acc_mem[cur_osc_o];
        end
        if (state_r == st_step) begin
            wave_addr_o <= byte_addr_w;
            halt_osc_o <= cur_osc_o;
            sample_o <= '0;
            sample_last_o <= last_w;
        end
        if ((state_r == st_fetch) && fetch_done_w) begin
            sample_o <= zero_byte_w ? '0 : product_w;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            for (int i = 0; i < num_osc; i++) begin
                acc_mem[i] <= '0;
            end
        end else begin
            if ((state_r == st_step) && !halted_w) begin
                acc_mem[cur_osc_o] <= overflow_w ? '0 : acc_sum_w;
            end
            // a zero byte rewinds the oscillator as well as halting it
            if ((state_r == st_fetch) && fetch_done_w && zero_byte_w) begin
                acc_mem[cur_osc_o] <= '0;
            end
        end
    end

endmodule

// ==== design/sample_fifo.sv ====
/* sample FIFO */

`timescale 1ns/1ps

module sample_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic             clk_i,
    input  logic             reset_n_i,
    input  logic             in_valid_i,
    input  doc_pkg::sample_t in_sample_i,
    input  logic             in_last_i,
    input  logic             out_ready_i,
    output logic             in_ready_o,
    output logic             out_valid_o,
    output doc_pkg::sample_t out_sample_o,
    output logic             out_last_o
);

    localparam int ptr_w = $clog2(fifo_depth);

    doc_pkg::sample_t sample_mem [fifo_depth];
    logic             last_mem [fifo_depth];

    logic [ptr_w-1:0] wr_ptr_r;
    logic [ptr_w-1:0] rd_ptr_r;
    logic [ptr_w:0]   count_r;
    logic             push_w;
    logic             pop_w;

    assign in_ready_o = (count_r != (ptr_w + 1)'(fifo_depth));
    assign out_valid_o = (count_r != '0);
    assign push_w = in_valid_i && in_ready_o;
    assign pop_w = out_valid_o && out_ready_i;

    // oldest entry is presented straight from storage
    assign out_sample_o = sample_mem[rd_ptr_r];
    assign out_last_o = last_mem[rd_ptr_r];

    always_ff @(posedge clk_i) begin
        if (push_w) begin
            sample_mem[wr_ptr_r] <= in_sample_i;
            last_mem[wr_ptr_r] <= in_last_i;
        end
    end

    // pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r <= '0;
        end else begin
            if (push_w) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (pop_w) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            if (push_w && !pop_w) begin
                count_r <= count_r + 1'b1;
            end else if (pop_w && !push_w) begin
                count_r <= count_r - 1'b1;
            end
        end
    end

endmodule

// ==== design/voice_mixer.sv ====
/* mono frame mixer */

`timescale 1ns/1ps

module voice_mixer (
    input  logic             clk_i,
    input  logic             reset_n_i,
    input  logic             in_valid_i,
    input  doc_pkg::sample_t in_sample_i,
    input  logic             in_last_i,
    output logic             in_ready_o,
    output logic             mix_valid_o,
    output doc_pkg::sample_t mix_o
);

    // running sum of the frame so far, wraps at 16 bits
    doc_pkg::sample_t sum_r;
    doc_pkg::sample_t next_sum_w;
    logic             accept_w;

    assign accept_w = in_valid_i && in_ready_o;
    assign next_sum_w = sum_r + in_sample_i;

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            in_ready_o <= 1'b0;
            mix_valid_o <= 1'b0;
            mix_o <= '0;
            sum_r <= '0;
        end else begin
            // ready once reset is released and stays there
            in_ready_o <= 1'b1;
            mix_valid_o <= 1'b0;
            if (accept_w) begin
                if (in_last_i) begin
                    // closing sample of the frame includes itself in the mix
                    mix_o <= next_sum_w;
                    mix_valid_o <= 1'b1;
                    sum_r <= '0;
                end else begin
                    sum_r <= next_sum_w;
                end
            end
        end
    end

endmodule

// ==== design/doc_top.sv ====
/* wavetable engine top */

`timescale 1ns/1ps

module doc_top #(
    parameter int fifo_depth = 4
) (
    input  logic                clk_i,
    input  logic                reset_n_i,
    input  logic                host_we_i,
    input  doc_pkg::reg_byte_t  host_addr_i,
    input  doc_pkg::reg_byte_t  host_data_i,
    input  logic                wave_rd_ready_i,
    input  doc_pkg::reg_byte_t  wave_data_i,
    output logic                wave_rd_valid_o,
    output doc_pkg::wave_addr_t wave_addr_o,
    output logic                mix_valid_o,
    output doc_pkg::sample_t    mix_o
);

    // register readout for the current oscillator
    logic [doc_pkg::osc_num_w-1:0] cur_osc;
    doc_pkg::freq_t                freq;
    doc_pkg::reg_byte_t            volume;
    doc_pkg::reg_byte_t            wave_ptr;
    doc_pkg::reg_byte_t            control;
    doc_pkg::reg_byte_t            res_size;
    logic [5:0]                    osc_count;

    // halt write-back into the control registers
    logic                          halt_req;
    logic [doc_pkg::osc_num_w-1:0] halt_osc;

    // sequencer to FIFO
    logic             seq_valid;
    doc_pkg::sample_t seq_sample;
    logic             seq_last;
    logic             fifo_ready;

    // FIFO to mixer
    logic             mix_in_valid;
    doc_pkg::sample_t mix_in_sample;
    logic             mix_in_last;
    logic             mixer_ready;

    doc_register_file u_register_file (
        .clk_i       (clk_i),
        .reset_n_i   (reset_n_i),
        .host_we_i   (host_we_i),
        .host_addr_i (host_addr_i),
        .host_data_i (host_data_i),
        .cur_osc_i   (cur_osc),
        .halt_req_i  (halt_req),
        .halt_osc_i  (halt_osc),
        .freq_o      (freq),
        .volume_o    (volume),
        .wave_ptr_o  (wave_ptr),
        .control_o   (control),
        .res_size_o  (res_size),
        .osc_count_o (osc_count)
    );

    osc_sequencer u_sequencer (
        .clk_i           (clk_i),
        .reset_n_i       (reset_n_i),
        .freq_i          (freq),
        .volume_i        (volume),
        .wave_ptr_i      (wave_ptr),
        .control_i       (control),
        .res_size_i      (res_size),
        .osc_count_i     (osc_count),
        .wave_rd_ready_i (wave_rd_ready_i),
        .wave_data_i     (wave_data_i),
        .sample_ready_i  (fifo_ready),
        .cur_osc_o       (cur_osc),
        .halt_req_o      (halt_req),
        .halt_osc_o      (halt_osc),
        .wave_rd_valid_o (wave_rd_valid_o),
        .wave_addr_o     (wave_addr_o),
        .sample_valid_o  (seq_valid),
        .sample_o        (seq_sample),
        .sample_last_o   (seq_last)
    );

    sample_fifo #(
        .fifo_depth (fifo_depth)
    ) u_sample_fifo (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .in_valid_i   (seq_valid),
        .in_sample_i  (seq_sample),
        .in_last_i    (seq_last),
        .out_ready_i  (mixer_ready),
        .in_ready_o   (fifo_ready),
        .out_valid_o  (mix_in_valid),
        .out_sample_o (mix_in_sample),
        .out_last_o   (mix_in_last)
    );

    voice_mixer u_mixer (
        .clk_i       (clk_i),
        .reset_n_i   (reset_n_i),
        .in_valid_i  (mix_in_valid),
        .in_sample_i (mix_in_sample),
        .in_last_i   (mix_in_last),
        .in_ready_o  (mixer_ready),
        .mix_valid_o (mix_valid_o),
        .mix_o       (mix_o)
    );

endmodule

// ==== test/tb_clock_gen.sv ====
/* testbench clock and reset */

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_n_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset stays low over the first 8 rising edges
    initial begin
        reset_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #2;
        reset_n_o = 1'b1;
    end

endmodule

// ==== test/tb_wave_memory.sv ====
/* wave memory model */

`timescale 1ns/1ps

module tb_wave_memory (
    input  logic                clk_i,
    input  doc_pkg::wave_addr_t addr_i,
    output logic                ready_o,
    output doc_pkg::reg_byte_t  data_o
);

    localparam logic [31:0] seed = 32'hc01b_076e;
    localparam logic [7:0]  zero_page = 8'h40;

    int unsigned seed_value;

    // both address bytes shape the contents, bit 0 forced so only page 40 hex reads zero
    always_comb begin
        if (addr_i[15:8] == zero_page) begin
            data_o = 8'h00;
        end else begin
            data_o = (addr_i[15:8] ^ addr_i[7:0]) | 8'h01;
        end
    end

    // ready is drawn fresh every cycle, high about three times in four
    initial begin
        ready_o = 1'b0;
        seed_value = $urandom(seed);
        forever begin
            @(posedge clk_i);
            #2;
            ready_o = ($urandom % 4) != 0;
        end
    end

endmodule

// ==== test/tb_doc_top.sv ====
/* wavetable engine testbench */

`timescale 1ns/1ps

module tb_doc_top;

    localparam int frames_idle = 4;
    localparam int frames_free = 24;
    localparam int frames_one_shot = 14;
    localparam int frames_zero_page = 6;
    localparam int frames_halt = 17;
    // each configured phase spends two more frames on the enable handover
    localparam int total_frames = frames_idle + frames_free + frames_one_shot
                                  + frames_zero_page + frames_halt + 8;
    localparam int watchdog_cycles = 200 * total_frames;

    logic                clk;
    logic                gen_reset_n;
    logic                phase_reset_n;
    logic                reset_n;
    logic                host_we;
    doc_pkg::reg_byte_t  host_addr;
    doc_pkg::reg_byte_t  host_data;
    logic                wave_rd_ready;
    doc_pkg::reg_byte_t  wave_data;
    logic                wave_rd_valid;
    doc_pkg::wave_addr_t wave_addr;
    logic                mix_valid;
    doc_pkg::sample_t    mix;

    // model of the register file and the accumulators
    doc_pkg::reg_byte_t ref_freq_lo [32];
    doc_pkg::reg_byte_t ref_freq_hi [32];
    doc_pkg::reg_byte_t ref_volume [32];
    doc_pkg::reg_byte_t ref_wave_ptr [32];
    doc_pkg::reg_byte_t ref_control [32];
    doc_pkg::reg_byte_t ref_res_size [32];
    doc_pkg::reg_byte_t ref_enable;
    doc_pkg::acc_t      ref_acc [32];
    // final control of oscillator 0, held back until the enable handover
    doc_pkg::reg_byte_t osc0_control;

    assign reset_n = gen_reset_n & phase_reset_n;

    tb_clock_gen u_clock_gen (
        .clk_o     (clk),
        .reset_n_o (gen_reset_n)
    );

    tb_wave_memory u_wave_memory (
        .clk_i   (clk),
        .addr_i  (wave_addr),
        .ready_o (wave_rd_ready),
        .data_o  (wave_data)
    );

    doc_top #(
        .fifo_depth (2)
    ) u_doc_top (
        .clk_i           (clk),
        .reset_n_i       (reset_n),
        .host_we_i       (host_we),
        .host_addr_i     (host_addr),
        .host_data_i     (host_data),
        .wave_rd_ready_i (wave_rd_ready),
        .wave_data_i     (wave_data),
        .wave_rd_valid_o (wave_rd_valid),
        .wave_addr_o     (wave_addr),
        .mix_valid_o     (mix_valid),
        .mix_o           (mix)
    );

    // wave memory contents as seen by the model
    function automatic doc_pkg::reg_byte_t wave_byte(input doc_pkg::wave_addr_t addr);
        if (addr[15:8] == 8'h40) begin
            return 8'h00;
        end
        return (addr[15:8] ^ addr[7:0]) | 8'h01;
    endfunction

    function automatic void reset_model();
        for (int i = 0; i < 32; i++) begin
            ref_freq_lo[i] = '0;
            ref_freq_hi[i] = '0;
            ref_volume[i] = '0;
            ref_wave_ptr[i] = '0;
            ref_control[i] = '0;
            ref_res_size[i] = '0;
            ref_acc[i] = '0;
        end
        ref_enable = 8'h02;
    endfunction

    function automatic void record_write(input doc_pkg::reg_byte_t addr,
                                         input doc_pkg::reg_byte_t data);
        logic [4:0] osc;
        osc = addr[4:0];
        case (addr[7:5])
            doc_pkg::grp_freq_lo:  ref_freq_lo[osc] = data;
            doc_pkg::grp_freq_hi:  ref_freq_hi[osc] = data;
            doc_pkg::grp_volume:   ref_volume[osc] = data;
            doc_pkg::grp_wave_ptr: ref_wave_ptr[osc] = data;
            doc_pkg::grp_control:  ref_control[osc] = data;
            doc_pkg::grp_res_size: ref_res_size[osc] = data;
            doc_pkg::grp_global: begin
                if (osc == 5'd1) begin
                    ref_enable = data;
                end
            end
            default: begin
            end
        endcase
    endfunction

    // steps every enabled oscillator once and returns the frame mix
    function automatic doc_pkg::sample_t expected_mix();
        int                count;
        int                size;
        int                shift;
        int                vol6;
        int                sample;
        doc_pkg::acc_t     acc_new;
        logic [15:0]       addr;
        logic [15:0]       offset;
        logic [7:0]        page;
        logic [7:0]        wave;
        logic signed [7:0] wave_s;
        logic              overflow;
        doc_pkg::sample_t  sum;
        count = ref_enable[5:1];
        if (count == 0) begin
            count = 1;
        end
        sum = '0;
        for (int osc = 0; osc < count; osc++) begin
            sample = 0;
            // a halted oscillator keeps its accumulator and stays silent
            if (!ref_control[osc][0]) begin
                size = ref_res_size[osc][5:3];
                shift = doc_pkg::addr_base_shift + ref_res_size[osc][2:0] - size;
                acc_new = ref_acc[osc] + {ref_freq_hi[osc], ref_freq_lo[osc]};
                addr = 16'(acc_new >> shift);
                overflow = addr[8 + size];
                offset = overflow ? 16'h0000 : (addr & ((16'h0001 << (8 + size)) - 16'h0001));
                page = ref_wave_ptr[osc] & (8'hff << size);
                ref_acc[osc] = overflow ? '0 : acc_new;
                if (overflow && (ref_control[osc][2:1] == doc_pkg::mode_one_shot)) begin
                    ref_control[osc][0] = 1'b1;
                end else begin
                    wave = wave_byte({page, 8'h00} | offset);
                    if (wave == 8'h00) begin
                        ref_control[osc][0] = 1'b1;
                        ref_acc[osc] = '0;
                    end else begin
                        wave_s = wave ^ 8'h80;
                        vol6 = ref_volume[osc] >> 2;
                        sample = wave_s * vol6;
                    end
                end
            end
            sum = sum + doc_pkg::sample_t'(sample);
        end
        return sum;
    endfunction

    task automatic drive_write(input doc_pkg::reg_byte_t addr, input doc_pkg::reg_byte_t data);
        host_we = 1'b1;
        host_addr = addr;
        host_data = data;
        @(posedge clk);
        #2;
        host_we = 1'b0;
    endtask

    task automatic host_write(input doc_pkg::reg_byte_t addr, input doc_pkg::reg_byte_t data);
        drive_write(addr, data);
        record_write(addr, data);
    endtask

    // returns 2 ns after the edge that raised mix_valid
    task automatic wait_mix();
        do begin
            @(posedge clk);
            #2;
        end while (!mix_valid);
    endtask

    task automatic run_frames(input int count);
        repeat (count) wait_mix();
    endtask

    task automatic apply_reset();
        phase_reset_n = 1'b0;
        reset_model();
        repeat (8) @(posedge clk);
        #2;
        phase_reset_n = 1'b1;
    endtask

    // oscillator 0 is halted first so it cannot move while the rest is written
    task automatic setup_osc(input logic [4:0] idx, input doc_pkg::freq_t freq,
                             input doc_pkg::reg_byte_t volume, input doc_pkg::reg_byte_t ptr,
                             input doc_pkg::reg_byte_t control, input doc_pkg::reg_byte_t res_size);
        if (idx == 5'd0) begin
            host_write({doc_pkg::grp_control, idx}, 8'h01);
            osc0_control = control;
        end
        host_write({doc_pkg::grp_freq_lo, idx}, freq[7:0]);
        host_write({doc_pkg::grp_freq_hi, idx}, freq[15:8]);
        host_write({doc_pkg::grp_volume, idx}, volume);
        host_write({doc_pkg::grp_wave_ptr, idx}, ptr);
        host_write({doc_pkg::grp_res_size, idx}, res_size);
        if (idx != 5'd0) begin
            host_write({doc_pkg::grp_control, idx}, control);
        end
    endtask

    // writes just after a mix miss oscillator 0 of the next frame, so that
    // frame still runs one halted oscillator and the new setup starts after it
    task automatic commit_setup(input int count);
        doc_pkg::reg_byte_t enable;
        enable = 8'(count << 1);
        wait_mix();
        drive_write({doc_pkg::grp_control, 5'd0}, osc0_control);
        drive_write({doc_pkg::grp_global, doc_pkg::global_osc_enable}, enable);
        wait_mix();
        record_write({doc_pkg::grp_control, 5'd0}, osc0_control);
        record_write({doc_pkg::grp_global, doc_pkg::global_osc_enable}, enable);
    endtask

    // every published mix is checked 1 ns after its edge
    initial begin
        doc_pkg::sample_t expected;
        forever begin
            @(posedge clk);
            #1;
            if (mix_valid) begin
                expected = expected_mix();
                assert (mix === expected) else begin
                    $display("error: time %0t mix %0d, expected %0d", $time, mix, expected);
                    $display("Done: errors found");
                    $fatal(1, "frame mix mismatch");
                end
            end
        end
    end

    // a wave read that meets a low ready keeps its request and address
    // ready is driven 2 ns after the edge, so at 1 ns it is what that edge saw
    initial begin
        logic                was_valid;
        doc_pkg::wave_addr_t held_addr;
        was_valid = 1'b0;
        held_addr = '0;
        forever begin
            @(posedge clk);
            #1;
            if (reset_n && was_valid && !wave_rd_ready) begin
                assert (wave_rd_valid && (wave_addr === held_addr)) else begin
                    $display("error: time %0t wave read dropped or moved, address %h, expected %h",
                             $time, wave_addr, held_addr);
                    $display("Done: errors found");
                    $fatal(1, "wave read handshake broken");
                end
            end
            was_valid = (wave_rd_valid === 1'b1);
            held_addr = wave_addr;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: no mix arrived in time after %0d cycles", watchdog_cycles);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        host_we = 1'b0;
        host_addr = '0;
        host_data = '0;
        phase_reset_n = 1'b1;
        osc0_control = '0;
        reset_model();
        wait (gen_reset_n);
        @(posedge clk);
        #2;

        // one oscillator at zero volume after reset
        run_frames(frames_idle);

        // four free-running voices, table sizes differ so they wrap at different frames
        apply_reset();
        setup_osc(5'd0, 16'h3000, 8'hfc, 8'h05, 8'h00, 8'h00);
        setup_osc(5'd1, 16'h6100, 8'h80, 8'h13, 8'h00, 8'h11);
        setup_osc(5'd2, 16'h2a00, 8'h40, 8'h22, 8'h00, 8'h08);
        setup_osc(5'd3, 16'h4321, 8'ha5, 8'h7f, 8'h00, 8'h18);
        commit_setup(4);
        run_frames(frames_free);

        // oscillator 0 in one-shot mode reaches its table end around frame 7
        apply_reset();
        setup_osc(5'd0, 16'h5000, 8'hff, 8'h09, 8'h02, 8'h00);
        setup_osc(5'd1, 16'h0800, 8'h30, 8'h31, 8'h00, 8'h00);
        commit_setup(2);
        run_frames(frames_one_shot);

        // oscillator 2 reads page 40 hex and halts on its first byte
        apply_reset();
        setup_osc(5'd0, 16'h1800, 8'h9c, 8'h0b, 8'h00, 8'h00);
        setup_osc(5'd1, 16'h2400, 8'h70, 8'h2e, 8'h00, 8'h08);
        setup_osc(5'd2, 16'h0100, 8'hff, 8'h40, 8'h00, 8'h00);
        commit_setup(3);
        run_frames(frames_zero_page);

        // the host halts oscillator 2 for a few frames and then lets it resume
        apply_reset();
        setup_osc(5'd0, 16'h2200, 8'hc8, 8'h03, 8'h00, 8'h09);
        setup_osc(5'd1, 16'h3c00, 8'h54, 8'h17, 8'h00, 8'h00);
        setup_osc(5'd2, 16'h5a00, 8'he0, 8'h26, 8'h00, 8'h02);
        setup_osc(5'd3, 16'h0f00, 8'h3c, 8'h68, 8'h00, 8'h10);
        commit_setup(4);
        run_frames(4);
        host_write({doc_pkg::grp_control, 5'd2}, 8'h01);
        run_frames(5);
        host_write({doc_pkg::grp_control, 5'd2}, 8'h00);
        run_frames(8);

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== verilog.f ====
design/doc_pkg.sv
design/doc_register_file.sv
design/osc_sequencer.sv
design/sample_fifo.sv
design/voice_mixer.sv
design/doc_top.sv
test/tb_clock_gen.sv
test/tb_wave_memory.sv
test/tb_doc_top.sv
